// ==== Bender.yml ====
package:
  name: sbuf

sources:
  - logic/sbuf_pkg.sv
  - logic/sbuf_ctrl.sv
  - logic/sbuf_bank_array.sv
  - logic/sbuf_rd_mux.sv
  - logic/sbuf_top.sv
  - target: simulation
    files:
      - sim/sbuf_props.sv
      - sim/sbuf_tb.sv

// ==== logic/sbuf_bank_array.sv ====
`timescale 1ns/1ps
`default_nettype none

module sbuf_bank_array import sbuf_pkg::*; #(
  parameter int DATA_W = SBUF_DATA_W_DEF
) (
  input  wire logic                                   nvdla_core_clk,
  input  wire logic [DATA_W-1:0]                      p0_wr_data,
  input  wire logic [DATA_W-1:0]                      p1_wr_data,
  input  wire logic [SBUF_BANK_NUM-1:0]               bank_we,
  input  wire logic [SBUF_BANK_NUM-1:0]               bank_wr_src,
  input  wire logic [SBUF_BANK_NUM-1:0][SBUF_BANK_AW-1:0] bank_wa,
  input  wire logic [SBUF_BANK_NUM-1:0]               bank_re,
  input  wire logic [SBUF_BANK_NUM-1:0][SBUF_BANK_AW-1:0] bank_ra,
  output logic [SBUF_BANK_NUM-1:0][DATA_W-1:0]        bank_rdata
);

  ////////////////////
  // single-port banks
  ////////////////////
  for (genvar b = 0; b < SBUF_BANK_NUM; b++) begin : g_bank
    logic [DATA_W-1:0] mem [SBUF_BANK_DEPTH];
    logic [DATA_W-1:0] wdat;
    logic [DATA_W-1:0] rdat;

    // src bit names the owning write port
    assign wdat = bank_wr_src[b] ? p1_wr_data : p0_wr_data;

    always_ff @(posedge nvdla_core_clk) begin
      if (bank_we[b]) begin
        mem[bank_wa[b]] <= wdat;
      end
    end

    // registered read, holds while re is low
    always_ff @(posedge nvdla_core_clk) begin
      if (bank_re[b]) begin
        rdat <= mem[bank_ra[b]];
      end
    end

    assign bank_rdata[b] = rdat;
  end

endmodule

`default_nettype wire

// ==== logic/sbuf_ctrl.sv ====
`timescale 1ns/1ps
`default_nettype none

module sbuf_ctrl import sbuf_pkg::*; (
  input  wire logic                                   nvdla_core_clk,
  input  wire logic                                   rst_n,
  input  wire logic                                   p0_wr_en,
  input  wire logic                                   p1_wr_en,
  input  wire sbuf_addr_u                             p0_wr_addr,
  input  wire sbuf_addr_u                             p1_wr_addr,
  input  wire logic                                   p0_rd_en,
  input  wire logic                                   p1_rd_en,
  input  wire logic                                   p0_rd_wg,
  input  wire logic                                   p1_rd_wg,
  input  wire sbuf_addr_u                             p0_rd_addr,
  input  wire sbuf_addr_u                             p1_rd_addr,
  output logic [SBUF_BANK_NUM-1:0]                    bank_we,
  output logic [SBUF_BANK_NUM-1:0]                    bank_wr_src,
  output logic [SBUF_BANK_NUM-1:0][SBUF_BANK_AW-1:0]  bank_wa,
  output logic [SBUF_BANK_NUM-1:0]                    bank_re,
  output logic [SBUF_BANK_NUM-1:0][SBUF_BANK_AW-1:0]  bank_ra,
  output logic [SBUF_BANK_NUM-1:0]                    p0_norm_sel_d1,
  output logic [SBUF_BANK_NUM-1:0]                    p1_norm_sel_d1,
  output logic [SBUF_GRP_NUM-1:0]                     p0_wg_grp_sel_d1,
  output logic [SBUF_GRP_NUM-1:0]                     p1_wg_grp_sel_d1,
  output logic [1:0]                                  p0_quarter_d1,
  output logic [1:0]                                  p1_quarter_d1,
  output logic                                        p0_rd_en_d1,
  output logic                                        p1_rd_en_d1
);

  // one-hot bank pick, all zero when en is low
  function automatic logic [SBUF_BANK_NUM-1:0] bank_hot(
    input logic                   en,
    input logic [SBUF_BSEL_W-1:0] idx
  );
    bank_hot      = '0;
    bank_hot[idx] = en;
  endfunction

  // one-hot group pick
  function automatic logic [SBUF_GRP_NUM-1:0] grp_hot(
    input logic                   en,
    input logic [SBUF_BSEL_W-3:0] idx
  );
    grp_hot      = '0;
    grp_hot[idx] = en;
  endfunction

  // spread a group pick over its four banks
  function automatic logic [SBUF_BANK_NUM-1:0] grp_banks(
    input logic [SBUF_GRP_NUM-1:0] gsel
  );
    for (int b = 0; b < SBUF_BANK_NUM; b++) begin
      grp_banks[b] = gsel[b / SBUF_GRP_SIZE];
    end
  endfunction

  logic [SBUF_BANK_NUM-1:0] p0_wr_sel;
  logic [SBUF_BANK_NUM-1:0] p1_wr_sel;
  logic [SBUF_BANK_NUM-1:0] p0_rd_norm;
  logic [SBUF_BANK_NUM-1:0] p1_rd_norm;
  logic [SBUF_GRP_NUM-1:0]  p0_rd_grp;
  logic [SBUF_GRP_NUM-1:0]  p1_rd_grp;
  logic [SBUF_BANK_NUM-1:0] p0_rd_sel;
  logic [SBUF_BANK_NUM-1:0] p1_rd_sel;
  logic [SBUF_BANK_AW-1:0]  p0_rd_entry;
  logic [SBUF_BANK_AW-1:0]  p1_rd_entry;

  ////////////////////
  // write decode
  ////////////////////
  assign p0_wr_sel = bank_hot(p0_wr_en, p0_wr_addr.norm.bank);
  assign p1_wr_sel = bank_hot(p1_wr_en, p1_wr_addr.norm.bank);

  // ports never share a bank, so p1 owning the bank picks p1
  assign bank_we     = p0_wr_sel | p1_wr_sel;
  assign bank_wr_src = p1_wr_sel;

  always_comb begin
    for (int b = 0; b < SBUF_BANK_NUM; b++) begin
      bank_wa[b] = p1_wr_sel[b] ? p1_wr_addr.norm.entry : p0_wr_addr.norm.entry;
    end
  end

  ////////////////////
  // read decode
  ////////////////////
  // normal read: one bank
  assign p0_rd_norm = bank_hot(p0_rd_en & ~p0_rd_wg, p0_rd_addr.norm.bank);
  assign p1_rd_norm = bank_hot(p1_rd_en & ~p1_rd_wg, p1_rd_addr.norm.bank);
  // winograd read: whole group
  assign p0_rd_grp  = grp_hot(p0_rd_en & p0_rd_wg, p0_rd_addr.wg.grp);
  assign p1_rd_grp  = grp_hot(p1_rd_en & p1_rd_wg, p1_rd_addr.wg.grp);

  assign p0_rd_sel = p0_rd_norm | grp_banks(p0_rd_grp);
  assign p1_rd_sel = p1_rd_norm | grp_banks(p1_rd_grp);

  // entry field sits at a different offset per view
  assign p0_rd_entry = p0_rd_wg ? p0_rd_addr.wg.entry : p0_rd_addr.norm.entry;
  assign p1_rd_entry = p1_rd_wg ? p1_rd_addr.wg.entry : p1_rd_addr.norm.entry;

  assign bank_re = p0_rd_sel | p1_rd_sel;

  always_comb begin
    for (int b = 0; b < SBUF_BANK_NUM; b++) begin
      bank_ra[b] = p1_rd_sel[b] ? p1_rd_entry : p0_rd_entry;
    end
  end

  ////////////////////
  // stage 1 flags
  ////////////////////
  // aligned with the registered ram output
  always_ff @(posedge nvdla_core_clk or negedge rst_n) begin
    if (!rst_n) begin
      p0_norm_sel_d1   <= '0;
      p1_norm_sel_d1   <= '0;
      p0_wg_grp_sel_d1 <= '0;
      p1_wg_grp_sel_d1 <= '0;
      p0_quarter_d1    <= '0;
      p1_quarter_d1    <= '0;
      p0_rd_en_d1      <= 1'b0;
      p1_rd_en_d1      <= 1'b0;
    end else begin
      p0_norm_sel_d1   <= p0_rd_norm;
      p1_norm_sel_d1   <= p1_rd_norm;
      p0_wg_grp_sel_d1 <= p0_rd_grp;
      p1_wg_grp_sel_d1 <= p1_rd_grp;
      // quarter only matters under a group select
      p0_quarter_d1    <= p0_rd_addr.wg.quarter;
      p1_quarter_d1    <= p1_rd_addr.wg.quarter;
      p0_rd_en_d1      <= p0_rd_en;
      p1_rd_en_d1      <= p1_rd_en;
    end
  end

endmodule

`default_nettype wire

// ==== logic/sbuf_pkg.sv ====
`default_nettype none

package sbuf_pkg;

  // bank geometry
  localparam int SBUF_BANK_NUM   = 8;
  localparam int SBUF_BANK_DEPTH = 16;
  localparam int SBUF_BANK_AW    = 4;
  localparam int SBUF_BSEL_W     = 3;
  // four banks per winograd group
  localparam int SBUF_GRP_SIZE   = 4;
  localparam int SBUF_GRP_NUM    = SBUF_BANK_NUM / SBUF_GRP_SIZE;
  localparam int SBUF_ADDR_W     = SBUF_BSEL_W + SBUF_BANK_AW;
  // must stay a multiple of 4 for the quarter slices
  localparam int SBUF_DATA_W_DEF = 64;

  // one address word, two ways to decode it
  typedef union packed {
    // normal access: bank on top, entry below
    struct packed {
      logic [SBUF_BSEL_W-1:0]  bank;
      logic [SBUF_BANK_AW-1:0] entry;
    } norm;
    // winograd read: group, entry, then quarter in the low bits
    struct packed {
      logic [SBUF_BSEL_W-3:0]  grp;
      logic [SBUF_BANK_AW-1:0] entry;
      logic [1:0]              quarter;
    } wg;
  } sbuf_addr_u;

endpackage

`default_nettype wire

// ==== logic/sbuf_rd_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

module sbuf_rd_mux import sbuf_pkg::*; #(
  parameter int DATA_W = SBUF_DATA_W_DEF
) (
  input  wire logic                                   nvdla_core_clk,
  input  wire logic [SBUF_BANK_NUM-1:0][DATA_W-1:0]   bank_rdata,
  input  wire logic [SBUF_BANK_NUM-1:0]               p0_norm_sel_d1,
  input  wire logic [SBUF_BANK_NUM-1:0]               p1_norm_sel_d1,
  input  wire logic [SBUF_GRP_NUM-1:0]                p0_wg_grp_sel_d1,
  input  wire logic [SBUF_GRP_NUM-1:0]                p1_wg_grp_sel_d1,
  input  wire logic [1:0]                             p0_quarter_d1,
  input  wire logic [1:0]                             p1_quarter_d1,
  input  wire logic                                   p0_rd_en_d1,
  input  wire logic                                   p1_rd_en_d1,
  output logic [DATA_W-1:0]                           p0_rd_data,
  output logic [DATA_W-1:0]                           p1_rd_data
);

  // quarter slice width
  localparam int QW = DATA_W / 4;

  // stage 2 gather for one port
  function automatic logic [DATA_W-1:0] gather(
    input logic [SBUF_BANK_NUM-1:0][DATA_W-1:0] rdat,
    input logic [SBUF_BANK_NUM-1:0]             norm_sel,
    input logic [SBUF_GRP_NUM-1:0]              grp_sel,
    input logic [1:0]                           quarter
  );
    logic [DATA_W-1:0]                    norm_word;
    logic [SBUF_GRP_SIZE-1:0][DATA_W-1:0] src;
    logic [DATA_W-1:0]                    wg_word;
    // and-or over one-hot bank select
    norm_word = '0;
    for (int b = 0; b < SBUF_BANK_NUM; b++) begin
      norm_word |= {DATA_W{norm_sel[b]}} & rdat[b];
    end
    // src[i] is bank i of the selected group
    src = '0;
    for (int g = 0; g < SBUF_GRP_NUM; g++) begin
      for (int i = 0; i < SBUF_GRP_SIZE; i++) begin
        src[i] |= {DATA_W{grp_sel[g]}} & rdat[g * SBUF_GRP_SIZE + i];
      end
    end
    // q-th slice of each, bank 3 on top
    for (int i = 0; i < SBUF_GRP_SIZE; i++) begin
      wg_word[i * QW +: QW] = src[i][quarter * QW +: QW];
    end
    // only one of the two is live
    return norm_word | wg_word;
  endfunction

  logic [DATA_W-1:0] p0_rdat;
  logic [DATA_W-1:0] p1_rdat;

  assign p0_rdat = gather(bank_rdata, p0_norm_sel_d1, p0_wg_grp_sel_d1, p0_quarter_d1);
  assign p1_rdat = gather(bank_rdata, p1_norm_sel_d1, p1_wg_grp_sel_d1, p1_quarter_d1);

  ////////////////////
  // output regs
  ////////////////////
  // held until the next read on the port lands
  always_ff @(posedge nvdla_core_clk) begin
    if (p0_rd_en_d1) begin
      p0_rd_data <= p0_rdat;
    end
    if (p1_rd_en_d1) begin
      p1_rd_data <= p1_rdat;
    end
  end

endmodule

`default_nettype wire

// ==== logic/sbuf_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module sbuf_top import sbuf_pkg::*; #(
  parameter int DATA_W = SBUF_DATA_W_DEF
) (
  input  wire logic               nvdla_core_clk,
  input  wire logic               rst_n,
  input  wire logic               p0_wr_en,
  input  wire sbuf_addr_u         p0_wr_addr,
  input  wire logic [DATA_W-1:0]  p0_wr_data,
  input  wire logic               p1_wr_en,
  input  wire sbuf_addr_u         p1_wr_addr,
  input  wire logic [DATA_W-1:0]  p1_wr_data,
  input  wire logic               p0_rd_en,
  input  wire logic               p0_rd_wg,
  input  wire sbuf_addr_u         p0_rd_addr,
  input  wire logic               p1_rd_en,
  input  wire logic               p1_rd_wg,
  input  wire sbuf_addr_u         p1_rd_addr,
  output logic [DATA_W-1:0]       p0_rd_data,
  output logic [DATA_W-1:0]       p1_rd_data
);

  // per-bank ram controls
  logic [SBUF_BANK_NUM-1:0]                   bank_we;
  logic [SBUF_BANK_NUM-1:0]                   bank_wr_src;
  logic [SBUF_BANK_NUM-1:0][SBUF_BANK_AW-1:0] bank_wa;
  logic [SBUF_BANK_NUM-1:0]                   bank_re;
  logic [SBUF_BANK_NUM-1:0][SBUF_BANK_AW-1:0] bank_ra;
  logic [SBUF_BANK_NUM-1:0][DATA_W-1:0]       bank_rdata;
  // stage 1 select state
  logic [SBUF_BANK_NUM-1:0]                   p0_norm_sel_d1;
  logic [SBUF_BANK_NUM-1:0]                   p1_norm_sel_d1;
  logic [SBUF_GRP_NUM-1:0]                    p0_wg_grp_sel_d1;
  logic [SBUF_GRP_NUM-1:0]                    p1_wg_grp_sel_d1;
  logic [1:0]                                 p0_quarter_d1;
  logic [1:0]                                 p1_quarter_d1;
  logic                                       p0_rd_en_d1;
  logic                                       p1_rd_en_d1;

  sbuf_ctrl ctrl_i (
    .nvdla_core_clk   (nvdla_core_clk),
    .rst_n            (rst_n),
    .p0_wr_en         (p0_wr_en),
    .p1_wr_en         (p1_wr_en),
    .p0_wr_addr       (p0_wr_addr),
    .p1_wr_addr       (p1_wr_addr),
    .p0_rd_en         (p0_rd_en),
    .p1_rd_en         (p1_rd_en),
    .p0_rd_wg         (p0_rd_wg),
    .p1_rd_wg         (p1_rd_wg),
    .p0_rd_addr       (p0_rd_addr),
    .p1_rd_addr       (p1_rd_addr),
    .bank_we          (bank_we),
    .bank_wr_src      (bank_wr_src),
    .bank_wa          (bank_wa),
    .bank_re          (bank_re),
    .bank_ra          (bank_ra),
    .p0_norm_sel_d1   (p0_norm_sel_d1),
    .p1_norm_sel_d1   (p1_norm_sel_d1),
    .p0_wg_grp_sel_d1 (p0_wg_grp_sel_d1),
    .p1_wg_grp_sel_d1 (p1_wg_grp_sel_d1),
    .p0_quarter_d1    (p0_quarter_d1),
    .p1_quarter_d1    (p1_quarter_d1),
    .p0_rd_en_d1      (p0_rd_en_d1),
    .p1_rd_en_d1      (p1_rd_en_d1)
  );

  sbuf_bank_array #(.DATA_W(DATA_W)) bank_array_i (
    .nvdla_core_clk (nvdla_core_clk),
    .p0_wr_data     (p0_wr_data),
    .p1_wr_data     (p1_wr_data),
    .bank_we        (bank_we),
    .bank_wr_src    (bank_wr_src),
    .bank_wa        (bank_wa),
    .bank_re        (bank_re),
    .bank_ra        (bank_ra),
    .bank_rdata     (bank_rdata)
  );

  sbuf_rd_mux #(.DATA_W(DATA_W)) rd_mux_i (
    .nvdla_core_clk   (nvdla_core_clk),
    .bank_rdata       (bank_rdata),
    .p0_norm_sel_d1   (p0_norm_sel_d1),
    .p1_norm_sel_d1   (p1_norm_sel_d1),
    .p0_wg_grp_sel_d1 (p0_wg_grp_sel_d1),
    .p1_wg_grp_sel_d1 (p1_wg_grp_sel_d1),
    .p0_quarter_d1    (p0_quarter_d1),
    .p1_quarter_d1    (p1_quarter_d1),
    .p0_rd_en_d1      (p0_rd_en_d1),
    .p1_rd_en_d1      (p1_rd_en_d1),
    .p0_rd_data       (p0_rd_data),
    .p1_rd_data       (p1_rd_data)
  );

endmodule

`default_nettype wire

// ==== sbuf.f ====
logic/sbuf_pkg.sv
logic/sbuf_ctrl.sv
logic/sbuf_bank_array.sv
logic/sbuf_rd_mux.sv
logic/sbuf_top.sv
sim/sbuf_props.sv
sim/sbuf_tb.sv

// ==== sim/sbuf_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module sbuf_props import sbuf_pkg::*; (
  input wire logic       nvdla_core_clk,
  input wire logic       rst_n,
  input wire logic       p0_wr_en,
  input wire sbuf_addr_u p0_wr_addr,
  input wire logic       p1_wr_en,
  input wire sbuf_addr_u p1_wr_addr,
  input wire logic       p0_rd_en,
  input wire logic       p0_rd_wg,
  input wire sbuf_addr_u p0_rd_addr,
  input wire logic       p1_rd_en,
  input wire logic       p1_rd_wg,
  input wire sbuf_addr_u p1_rd_addr
);

  // bumped by each failing check, read by the testbench
  int unsigned fails = 0;

  // banks a read occupies
  function automatic logic [SBUF_BANK_NUM-1:0] banks_of(
    input logic       en,
    input logic       wg,
    input sbuf_addr_u a
  );
    banks_of = '0;
    if (en && wg) begin
      for (int i = 0; i < SBUF_GRP_SIZE; i++) begin
        banks_of[a.wg.grp * SBUF_GRP_SIZE + i] = 1'b1;
      end
    end else if (en) begin
      banks_of[a.norm.bank] = 1'b1;
    end
  endfunction

  // write and read on the same bank and entry
  function automatic logic rw_clash(
    input logic       we,
    input sbuf_addr_u wa,
    input logic       re,
    input logic       wg,
    input sbuf_addr_u ra
  );
    logic [SBUF_BANK_NUM-1:0] m;
    logic [SBUF_BANK_AW-1:0]  e;
    m = banks_of(re, wg, ra);
    e = wg ? ra.wg.entry : ra.norm.entry;
    return we && m[wa.norm.bank] && (e == wa.norm.entry);
  endfunction

  ////////////////////
  // caller rules
  ////////////////////
  wr_bank_apart: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    !(p0_wr_en && p1_wr_en && (p0_wr_addr.norm.bank == p1_wr_addr.norm.bank)))
    else begin
      $error("both write ports address one bank");
      fails++;
    end

  rd_bank_apart: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    (banks_of(p0_rd_en, p0_rd_wg, p0_rd_addr)
      & banks_of(p1_rd_en, p1_rd_wg, p1_rd_addr)) == '0)
    else begin
      $error("read ports share a bank");
      fails++;
    end

  // any write port against any read port
  rd_wr_apart: assert property (@(posedge nvdla_core_clk) disable iff (!rst_n)
    !(rw_clash(p0_wr_en, p0_wr_addr, p0_rd_en, p0_rd_wg, p0_rd_addr)
      || rw_clash(p0_wr_en, p0_wr_addr, p1_rd_en, p1_rd_wg, p1_rd_addr)
      || rw_clash(p1_wr_en, p1_wr_addr, p0_rd_en, p0_rd_wg, p0_rd_addr)
      || rw_clash(p1_wr_en, p1_wr_addr, p1_rd_en, p1_rd_wg, p1_rd_addr)))
    else begin
      $error("read and write hit one bank entry");
      fails++;
    end

endmodule

bind sbuf_top sbuf_props props_i (
  .nvdla_core_clk (nvdla_core_clk),
  .rst_n          (rst_n),
  .p0_wr_en       (p0_wr_en),
  .p0_wr_addr     (p0_wr_addr),
  .p1_wr_en       (p1_wr_en),
  .p1_wr_addr     (p1_wr_addr),
  .p0_rd_en       (p0_rd_en),
  .p0_rd_wg       (p0_rd_wg),
  .p0_rd_addr     (p0_rd_addr),
  .p1_rd_en       (p1_rd_en),
  .p1_rd_wg       (p1_rd_wg),
  .p1_rd_addr     (p1_rd_addr)
);

`default_nettype wire

// ==== sim/sbuf_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module sbuf_tb import sbuf_pkg::*;;

  localparam int DATA_W = SBUF_DATA_W_DEF;
  localparam int QW     = DATA_W / 4;
  localparam int CLK_NS = 40;
  localparam int N_ADDR = SBUF_BANK_NUM * SBUF_BANK_DEPTH;

  // cycles spent by each test
  localparam int FILL_OPS  = 2 * N_ADDR;
  localparam int PAIR_OPS  = 2;
  localparam int WG_OPS    = SBUF_GRP_NUM * SBUF_BANK_DEPTH * 4;
  localparam int MIX_OPS   = 16;
  localparam int B2B_OPS   = 8 + 4;
  localparam int RAND_OPS  = 2000;
  localparam int DRAIN_OPS = 5 * 3;
  localparam int N_OPS     = 3 + FILL_OPS + PAIR_OPS + WG_OPS + MIX_OPS + B2B_OPS
                             + RAND_OPS + DRAIN_OPS;

  logic              clk;
  logic              rst_n;
  logic              w_en    [2];
  sbuf_addr_u        w_addr  [2];
  logic [DATA_W-1:0] w_data  [2];
  logic              r_en    [2];
  logic              r_wg    [2];
  sbuf_addr_u        r_addr  [2];
  logic [DATA_W-1:0] rd_data [2];

  // reference memory, one word per bank and entry
  logic [DATA_W-1:0] model [SBUF_BANK_NUM][SBUF_BANK_DEPTH];
  // expected words per port, oldest first
  logic [DATA_W-1:0] exp_q [2][$];
  // read issued 0, 1 and 2 cycles back, one bit per port
  logic [1:0]        rd_d0 = '0;
  logic [1:0]        rd_d1 = '0;
  logic [1:0]        rd_d2 = '0;
  logic [DATA_W-1:0] last_val  [2];
  logic              have_last [2];
  logic [31:0]       seed = 32'h1be677eb;
  int unsigned       errors = 0;
  string             cur_test = "reset";

  sbuf_top #(.DATA_W(DATA_W)) dut_i (
    .nvdla_core_clk (clk),
    .rst_n          (rst_n),
    .p0_wr_en       (w_en[0]),
    .p0_wr_addr     (w_addr[0]),
    .p0_wr_data     (w_data[0]),
    .p1_wr_en       (w_en[1]),
    .p1_wr_addr     (w_addr[1]),
    .p1_wr_data     (w_data[1]),
    .p0_rd_en       (r_en[0]),
    .p0_rd_wg       (r_wg[0]),
    .p0_rd_addr     (r_addr[0]),
    .p1_rd_en       (r_en[1]),
    .p1_rd_wg       (r_wg[1]),
    .p1_rd_addr     (r_addr[1]),
    .p0_rd_data     (rd_data[0]),
    .p1_rd_data     (rd_data[1])
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_NS / 2) clk = ~clk;
  end

  ////////////////////
  // stimulus helpers
  ////////////////////
  // xorshift32
  function automatic logic [31:0] next_rand();
    seed ^= seed << 13;
    seed ^= seed >> 17;
    seed ^= seed << 5;
    return seed;
  endfunction

  function automatic logic [DATA_W-1:0] rand_word();
    logic [DATA_W-1:0] w;
    w = '0;
    for (int i = 0; i < DATA_W; i += 32) begin
      w = (w << 32) | DATA_W'(next_rand());
    end
    return w;
  endfunction

  function automatic sbuf_addr_u norm_addr(input int b, input int e);
    sbuf_addr_u a;
    a.norm.bank  = b[SBUF_BSEL_W-1:0];
    a.norm.entry = e[SBUF_BANK_AW-1:0];
    return a;
  endfunction

  function automatic sbuf_addr_u wg_addr(input int g, input int e, input int q);
    sbuf_addr_u a;
    a.wg.grp     = g[0];
    a.wg.entry   = e[SBUF_BANK_AW-1:0];
    a.wg.quarter = q[1:0];
    return a;
  endfunction

  // banks a read occupies, a whole group in winograd mode
  function automatic logic [SBUF_BANK_NUM-1:0] rd_banks(
    input logic       en,
    input logic       wg,
    input sbuf_addr_u a
  );
    rd_banks = '0;
    if (en && wg) begin
      for (int i = 0; i < SBUF_GRP_SIZE; i++) begin
        rd_banks[a.wg.grp * SBUF_GRP_SIZE + i] = 1'b1;
      end
    end else if (en) begin
      rd_banks[a.norm.bank] = 1'b1;
    end
  endfunction

  function automatic logic [SBUF_BANK_AW-1:0] rd_entry(input logic wg, input sbuf_addr_u a);
    return wg ? a.wg.entry : a.norm.entry;
  endfunction

  // winograd word is the q-th slice of banks 0..3, bank 3 on top
  function automatic logic [DATA_W-1:0] expect_word(input logic wg, input sbuf_addr_u a);
    logic [DATA_W-1:0] w;
    int                g;
    int                q;
    if (!wg) begin
      return model[a.norm.bank][a.norm.entry];
    end
    g = a.wg.grp;
    q = a.wg.quarter;
    for (int i = 0; i < SBUF_GRP_SIZE; i++) begin
      w[i * QW +: QW] = model[g * SBUF_GRP_SIZE + i][a.wg.entry][q * QW +: QW];
    end
    return w;
  endfunction

  // write would land on a bank entry that a read of this cycle uses
  function automatic logic wr_blocked(input int p);
    logic [SBUF_BANK_NUM-1:0] m;
    logic                     hit;
    hit = 1'b0;
    for (int q = 0; q < 2; q++) begin
      m = rd_banks(r_en[q], r_wg[q], r_addr[q]);
      if (m[w_addr[p].norm.bank] && rd_entry(r_wg[q], r_addr[q]) == w_addr[p].norm.entry) begin
        hit = 1'b1;
      end
    end
    return hit;
  endfunction

  task automatic idle_inputs();
    for (int p = 0; p < 2; p++) begin
      w_en[p]   = 1'b0;
      w_addr[p] = '0;
      w_data[p] = '0;
      r_en[p]   = 1'b0;
      r_wg[p]   = 1'b0;
      r_addr[p] = '0;
    end
  endtask

  task automatic set_wr(input int p, input int b, input int e, input logic [DATA_W-1:0] d);
    w_en[p]   = 1'b1;
    w_addr[p] = norm_addr(b, e);
    w_data[p] = d;
  endtask

  task automatic set_rd(input int p, input logic wg, input sbuf_addr_u a);
    r_en[p]   = 1'b1;
    r_wg[p]   = wg;
    r_addr[p] = a;
  endtask

  // one legal cycle: disjoint reads, distinct write banks, no hazard
  task automatic random_cycle();
    logic [31:0] r;
    int          b1;
    r         = next_rand();
    r_en[0]   = r[0];
    r_wg[0]   = r[1];
    r_addr[0] = r[14:8];
    // redraw port 1 until it misses port 0's banks
    do begin
      r         = next_rand();
      r_en[1]   = r[0];
      r_wg[1]   = r[1];
      r_addr[1] = r[14:8];
    end while ((rd_banks(r_en[0], r_wg[0], r_addr[0])
                & rd_banks(r_en[1], r_wg[1], r_addr[1])) != '0);
    r         = next_rand();
    b1        = (r[2:0] + 1 + r[10:8] % 7) % SBUF_BANK_NUM;
    w_en[0]   = r[3];
    w_en[1]   = r[11];
    w_addr[0] = norm_addr(r[2:0], r[7:4]);
    w_addr[1] = norm_addr(b1, r[15:12]);
    w_data[0] = rand_word();
    w_data[1] = rand_word();
    for (int p = 0; p < 2; p++) begin
      if (w_en[p] && wr_blocked(p)) begin
        w_en[p] = 1'b0;
      end
    end
  endtask

  ////////////////////
  // checking
  ////////////////////
  task automatic check_rd(
    input string             name,
    input logic [DATA_W-1:0] exp,
    input logic [DATA_W-1:0] act
  );
    if (act !== exp) begin
      errors++;
      $display("Error %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  // finished read, or held data when none finished
  task automatic check_port(input int p);
    logic [DATA_W-1:0] exp;
    if (rd_d2[p]) begin
      exp          = exp_q[p].pop_front();
      check_rd(cur_test, exp, rd_data[p]);
      last_val[p]  = exp;
      have_last[p] = 1'b1;
    end else if (have_last[p]) begin
      check_rd({cur_test, " hold"}, last_val[p], rd_data[p]);
    end
  endtask

  // commit this cycle's inputs, move to the next drive point
  task automatic tick();
    for (int p = 0; p < 2; p++) begin
      if (r_en[p]) begin
        exp_q[p].push_back(expect_word(r_wg[p], r_addr[p]));
      end
      rd_d0[p] = r_en[p];
    end
    for (int p = 0; p < 2; p++) begin
      if (w_en[p]) begin
        model[w_addr[p].norm.bank][w_addr[p].norm.entry] = w_data[p];
      end
    end
    @(posedge clk);
    #2;
    idle_inputs();
    rd_d2 = rd_d1;
    rd_d1 = rd_d0;
    for (int p = 0; p < 2; p++) begin
      check_port(p);
    end
  endtask

  task automatic drain();
    repeat (3) tick();
  endtask

  ////////////////////
  // watchdog
  ////////////////////
  initial begin
    #((N_OPS + 20) * CLK_NS);
    $display("timeout: run did not finish within %0d cycles", N_OPS + 20);
    $display("sim failed");
    $finish;
  end

  ////////////////////
  // tests
  ////////////////////
  initial begin
    int g;
    int n;
    rst_n = 1'b0;
    idle_inputs();
    have_last[0] = 1'b0;
    have_last[1] = 1'b0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;

    // every entry through alternating ports
    cur_test = "fill";
    for (int a = 0; a < N_ADDR; a++) begin
      set_wr(a % 2, a / SBUF_BANK_DEPTH, a % SBUF_BANK_DEPTH, rand_word());
      tick();
    end
    cur_test = "normal read";
    for (int a = 0; a < N_ADDR; a++) begin
      set_rd(a % 2, 1'b0, norm_addr(a / SBUF_BANK_DEPTH, a % SBUF_BANK_DEPTH));
      tick();
    end
    drain();

    // both write ports in one cycle, crossed reads
    cur_test = "dual write";
    set_wr(0, 2, 5, rand_word());
    set_wr(1, 6, 9, rand_word());
    tick();
    set_rd(0, 1'b0, norm_addr(6, 9));
    set_rd(1, 1'b0, norm_addr(2, 5));
    tick();
    drain();

    cur_test = "winograd read";
    n = 0;
    for (int gi = 0; gi < SBUF_GRP_NUM; gi++) begin
      for (int e = 0; e < SBUF_BANK_DEPTH; e++) begin
        for (int q = 0; q < 4; q++) begin
          set_rd(n % 2, 1'b1, wg_addr(gi, e, q));
          tick();
          n++;
        end
      end
    end
    drain();

    // winograd on one group, normal read in the other
    cur_test = "mixed modes";
    for (int i = 0; i < MIX_OPS; i++) begin
      g = next_rand() % 2;
      set_rd(i % 2, 1'b1, wg_addr(g, next_rand() % 16, next_rand() % 4));
      set_rd(1 - i % 2, 1'b0, norm_addr((1 - g) * 4 + next_rand() % 4, next_rand() % 16));
      tick();
    end
    drain();

    // reads every cycle, then idle so data must hold
    cur_test = "back to back";
    for (int i = 0; i < 8; i++) begin
      set_rd(0, 1'b0, norm_addr(i, 15 - i));
      tick();
    end
    repeat (4) tick();

    cur_test = "random";
    for (int i = 0; i < RAND_OPS; i++) begin
      random_cycle();
      tick();
    end
    drain();

    $display("data errors: %0d, assertion failures: %0d", errors, dut_i.props_i.fails);
    if (errors == 0 && dut_i.props_i.fails == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
